// ==== compile.f ====
verilog/fp_mul_pkg.sv
verilog/fp_operand_unpack.sv
verilog/fp_mant_multiply.sv
verilog/fp_normalize_round.sv
verilog/fp_result_pack.sv
verilog/fp_mul.sv
testbench/fp_mul_assertions.sv
testbench/tb_fp_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fp_mul testbench with verilator, run it and check for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_fp_mul \
	-Mdir obj_dir || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_fp_mul 2>&1)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && echo "simulation passed" && exit 0 || {
	echo "simulation failed"
	exit 1
}

// ==== testbench/tb_fp_mul.sv ====
// tb_fp_mul: directed tests of the pipelined single precision multiplier against a reference model
`timescale 1ns/1ps

module tb_fp_mul import fp_mul_pkg::*;;

	localparam int TAG_W   = 6;
	localparam int TIMEOUT = 20;	// cycles allowed for any wait

	// expected flags {nv, of, uf, nx}
	localparam logic [3:0] F_NONE = 4'b0000;
	localparam logic [3:0] F_NV   = 4'b1000;
	localparam logic [3:0] F_OFNX = 4'b0101;
	localparam logic [3:0] F_UFNX = 4'b0011;

	logic             clk;
	logic             reset;
	logic             start;
	round_mode_t      rnd;
	logic [31:0]      in_1, in_2;
	logic [TAG_W-1:0] tag;
	logic             valid;
	logic [31:0]      res;
	logic [TAG_W-1:0] tag_out;
	logic             nv, of, uf, nx;

	logic [31:0]      lfsr;
	logic [TAG_W-1:0] op_tag;
	int               n_checks, n_mismatch, n_timeout, n_other, n_assert;

	fp_mul #(.TAG_W(TAG_W)) dut_i (
		.clk(clk), .reset(reset), .start(start), .rnd(rnd), .in_1(in_1), .in_2(in_2),
		.tag(tag), .valid(valid), .res(res), .tag_out(tag_out),
		.nv(nv), .of(of), .uf(uf), .nx(nx)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// normal operand, exponent kept near the middle of the range
	function automatic logic [31:0] rand_normal();
		logic [31:0] r_s, r_e, r_f;
		r_s = rand_bits(1);
		r_e = rand_bits(5);
		r_f = rand_bits(23);
		return {r_s[0], 8'd112 + r_e[7:0], r_f[22:0]};
	endfunction

	// returns {nv, of, uf, nx, result}
	function automatic logic [35:0] ref_mul(input logic [31:0] a, input logic [31:0] b,
			input int mode);
		logic        s, a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, bad;
		logic        g, st, inc, toward_zero;
		int          e;
		logic [47:0] p;
		logic [24:0] m;
		s      = a[31] ^ b[31];
		a_zero = a[30:23] == 8'h00;	// subnormals count as zero
		b_zero = b[30:23] == 8'h00;
		a_inf  = a[30:23] == 8'hFF && a[22:0] == 0;
		b_inf  = b[30:23] == 8'hFF && b[22:0] == 0;
		a_nan  = a[30:23] == 8'hFF && a[22:0] != 0;
		b_nan  = b[30:23] == 8'hFF && b[22:0] != 0;
		bad    = (a_inf || b_inf) && (a_zero || b_zero);
		if (a_nan || b_nan || bad)
			return {(a_nan && !a[22]) || (b_nan && !b[22]) || bad, 3'b000, 32'h7FC0_0000};
		if (a_inf || b_inf)
			return {F_NONE, s, 8'hFF, 23'h0};
		if (a_zero || b_zero)
			return {F_NONE, s, 31'h0};
		p = {24'h0, 1'b1, a[22:0]} * {24'h0, 1'b1, b[22:0]};
		e = int'(a[30:23]) + int'(b[30:23]) - 127;
		if (p[47])
			e = e + 1;
		else
			p = p << 1;	// leading one always at bit 47
		g  = p[23];
		st = |p[22:0];
		case (mode)
			0: inc = g && (st || p[24]);
			2: inc = s && (g || st);
			3: inc = !s && (g || st);
			4: inc = g;
			default: inc = 1'b0;
		endcase
		m = {1'b0, p[47:24]} + 25'(inc);
		if (m[24]) begin
			e = e + 1;
			m = m >> 1;
		end
		if (e >= 255) begin
			toward_zero = (mode == 1) || (mode == 2 && !s) || (mode == 3 && s);
			return {F_OFNX, s, toward_zero ? 31'h7F7F_FFFF : 31'h7F80_0000};
		end
		if (e < 1)
			return {F_UFNX, s, 31'h0};
		return {3'b000, g || st, s, 8'(e), m[22:0]};
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		n_checks++;
		if (got !== expected) begin
			n_mismatch++;
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic check_result(input logic [35:0] expected, input logic [TAG_W-1:0] exp_tag);
		check_field("res", res, expected[31:0]);
		check_field("nx", 32'(nx), 32'(expected[32]));
		check_field("uf", 32'(uf), 32'(expected[33]));
		check_field("of", 32'(of), 32'(expected[34]));
		check_field("nv", 32'(nv), 32'(expected[35]));
		check_field("tag_out", 32'(tag_out), 32'(exp_tag));
	endtask

	task automatic wait_valid(output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < TIMEOUT) begin
			@(negedge clk);
			if (valid)
				seen = 1'b1;
			n++;
		end
		if (!seen) begin
			n_timeout++;
			$display("timeout at %0t: no valid result after an issued operation", $time);
		end
	endtask

	task automatic run_op(input logic [31:0] a, input logic [31:0] b, input int mode,
			input logic [35:0] expected);
		logic             seen;
		logic [TAG_W-1:0] t;
		t = op_tag;
		op_tag++;
		@(posedge clk);
		start <= 1'b1;
		in_1  <= a;
		in_2  <= b;
		rnd   <= round_mode_t'(mode);
		tag   <= t;
		@(posedge clk);
		start <= 1'b0;
		wait_valid(seen);
		if (seen)
			check_result(expected, t);
	endtask

	task automatic apply_reset();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_field("valid", 32'(valid), 32'h0);
	endtask

	task automatic test_exact();
		for (int m = 0; m < 5; m++) begin
			run_op(32'h3FC0_0000, 32'h4000_0000, m, {F_NONE, 32'h4040_0000});	// 1.5 * 2
			run_op(32'hBF00_0000, 32'h4080_0000, m, {F_NONE, 32'hC000_0000});	// -0.5 * 4
		end
	endtask

	task automatic test_random();
		logic [31:0] a, b;
		for (int i = 0; i < 16; i++) begin
			a = rand_normal();
			b = rand_normal();
			for (int m = 0; m < 5; m++)
				run_op(a, b, m, ref_mul(a, b, m));
		end
	endtask

	task automatic test_special();
		run_op(32'h7FC1_2345, 32'h3F80_0000, 0, {F_NONE, 32'h7FC0_0000});	// quiet nan
		run_op(32'h3F80_0000, 32'h7F80_0001, 0, {F_NV, 32'h7FC0_0000});	// signalling nan
		run_op(32'h7F80_0000, 32'h0000_0000, 0, {F_NV, 32'h7FC0_0000});
		run_op(32'h7F80_0000, 32'hC000_0000, 3, {F_NONE, 32'hFF80_0000});
		run_op(32'h0000_0000, 32'h40A0_0000, 0, {F_NONE, 32'h0000_0000});
		run_op(32'h8000_0000, 32'h40A0_0000, 0, {F_NONE, 32'h8000_0000});
		run_op(32'h0000_0000, 32'hC0A0_0000, 2, {F_NONE, 32'h8000_0000});
		run_op(32'h0000_0001, 32'h3F80_0000, 0, {F_NONE, 32'h0000_0000});	// subnormal
		run_op(32'h8040_0000, 32'h40A0_0000, 0, {F_NONE, 32'h8000_0000});
	endtask

	task automatic test_overflow();
		logic sat;
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 5; m++) begin
				sat = (m == 1) || (m == 2 && s == 0) || (m == 3 && s == 1);
				run_op({s[0], 31'h7F00_0000}, 32'h7F00_0000, m,
					{F_OFNX, s[0], sat ? 31'h7F7F_FFFF : 31'h7F80_0000});
			end
		end
	endtask

	task automatic test_underflow();
		for (int m = 0; m < 5; m++) begin
			run_op(32'h0080_0000, 32'h0080_0000, m, {F_UFNX, 32'h0000_0000});
			run_op(32'h8080_0000, 32'h0080_0000, m, {F_UFNX, 32'h8000_0000});
			run_op(32'h2000_0000, 32'h1F80_0000, m, {F_UFNX, 32'h0000_0000});	// 2^-127
		end
	endtask

	task automatic test_back_to_back();
		logic [31:0]      a_q [8];
		logic [31:0]      b_q [8];
		logic [35:0]      exp_q [8];
		logic [TAG_W-1:0] tag_q [8];
		int               start_cyc [$];
		int               got, cyc, issued;
		for (int i = 0; i < 8; i++) begin
			a_q[i]   = rand_normal();
			b_q[i]   = rand_normal();
			exp_q[i] = ref_mul(a_q[i], b_q[i], i % 5);
			tag_q[i] = TAG_W'(6'h30 + i);
		end
		fork
			begin
				for (int i = 0; i < 8; i++) begin
					@(posedge clk);
					start <= 1'b1;
					in_1  <= a_q[i];
					in_2  <= b_q[i];
					rnd   <= round_mode_t'(i % 5);
					tag   <= tag_q[i];
				end
				@(posedge clk);
				start <= 1'b0;
			end
			begin
				got = 0;
				cyc = 0;
				while (got < 8 && cyc < 8 + TIMEOUT) begin
					@(negedge clk);
					if (start)
						start_cyc.push_back(cyc);
					if (valid) begin
						if (start_cyc.size() == 0) begin
							n_other++;
							$display("valid at %0t with no operation in flight", $time);
						end else begin
							issued = start_cyc.pop_front();
							check_field("latency", 32'(cyc - issued), 32'd2);
							check_result(exp_q[got], tag_q[got]);
						end
						got++;
					end
					cyc++;
				end
				if (got < 8) begin
					n_timeout++;
					$display("timeout at %0t: only %0d of 8 results returned", $time, got);
				end
			end
		join
	endtask

	initial begin
		clk        = 1'b0;
		reset      = 1'b1;
		start      = 1'b0;
		rnd        = RNE;
		in_1       = '0;
		in_2       = '0;
		tag        = '0;
		lfsr       = 32'h9d0a_4a57;
		op_tag     = '0;
		n_checks   = 0;
		n_mismatch = 0;
		n_timeout  = 0;
		n_other    = 0;
		apply_reset();
		test_exact();
		test_random();
		test_special();
		test_overflow();
		test_underflow();
		test_back_to_back();
		n_assert = int'(dut_i.u_assert.fail_count);
		$display("checks %0d, mismatches %0d, timeouts %0d, other %0d, assertion failures %0d",
			n_checks, n_mismatch, n_timeout, n_other, n_assert);
		if (n_mismatch + n_timeout + n_other + n_assert == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== testbench/fp_mul_assertions.sv ====
// fp_mul_assertions: bound checker for the fp_mul start to valid timing and tag order
`timescale 1ns/1ps

module fp_mul_assertions #(
	parameter int TAG_W = 6
) (
	input logic             clk,
	input logic             reset,
	input logic             start,
	input logic [TAG_W-1:0] tag,
	input logic             valid,
	input logic [TAG_W-1:0] tag_out
);

	int unsigned fail_count = 0;	// summed into the testbench error total

	// pipeline empty right after reset
	valid_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !valid)
		else begin
			$error("valid high in the first cycle after reset");
			fail_count++;
		end

	// two register stages, no stall
	valid_follows_start: assert property (@(posedge clk) disable iff (reset)
		valid == $past(start, 2))
		else begin
			$error("valid does not follow start by two cycles");
			fail_count++;
		end

	tag_follows_issue: assert property (@(posedge clk) disable iff (reset)
		valid |-> tag_out == $past(tag, 2))
		else begin
			$error("tag_out differs from the tag issued two cycles earlier");
			fail_count++;
		end

endmodule

bind fp_mul fp_mul_assertions #(.TAG_W(TAG_W)) u_assert (
	.clk(clk), .reset(reset), .start(start), .tag(tag), .valid(valid), .tag_out(tag_out)
);

// ==== verilog/fp_mul.sv ====
// fp_mul: two cycle pipelined single precision multiplier with rounding modes and flags
`timescale 1ns/1ps

module fp_mul import fp_mul_pkg::*; #(
	parameter int TAG_W = 6
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  round_mode_t      rnd,
	input  logic [FP_W-1:0]  in_1,
	input  logic [FP_W-1:0]  in_2,
	input  logic [TAG_W-1:0] tag,
	output logic             valid,
	output logic [FP_W-1:0]  res,
	output logic [TAG_W-1:0] tag_out,
	output logic             nv,
	output logic             of,
	output logic             uf,
	output logic             nx
);

	// stage b
	logic                     b_valid, b_sign, b_snan;
	logic [TAG_W-1:0]         b_tag;
	round_mode_t              b_rnd;
	logic signed [SEXP_W-1:0] b_exp_sum;
	logic [MANT_W-1:0]        b_mant_1, b_mant_2;
	fp_class_t                b_class_1, b_class_2;

	// stage c
	logic                     c_valid, c_sign, c_snan;
	logic [TAG_W-1:0]         c_tag;
	round_mode_t              c_rnd;
	logic signed [SEXP_W-1:0] c_exp_sum;
	logic [PROD_W-1:0]        c_product;
	fp_class_t                c_class_1, c_class_2;

	logic [EXP_W-1:0]  rnd_exp;
	logic [FRAC_W-1:0] rnd_frac;
	logic              overflow, underflow, inexact, max_finite;

	fp_operand_unpack #(.TAG_W(TAG_W)) u_unpack (
		.clk(clk), .reset(reset), .start(start), .rnd(rnd),
		.in_1(in_1), .in_2(in_2), .tag(tag),
		.b_valid(b_valid), .b_tag(b_tag), .b_rnd(b_rnd), .b_sign(b_sign),
		.b_exp_sum(b_exp_sum), .b_mant_1(b_mant_1), .b_mant_2(b_mant_2),
		.b_class_1(b_class_1), .b_class_2(b_class_2), .b_snan(b_snan)
	);

	fp_mant_multiply #(.TAG_W(TAG_W)) u_multiply (
		.clk(clk), .reset(reset),
		.b_valid(b_valid), .b_tag(b_tag), .b_rnd(b_rnd), .b_sign(b_sign),
		.b_exp_sum(b_exp_sum), .b_mant_1(b_mant_1), .b_mant_2(b_mant_2),
		.b_class_1(b_class_1), .b_class_2(b_class_2), .b_snan(b_snan),
		.c_valid(c_valid), .c_tag(c_tag), .c_rnd(c_rnd), .c_sign(c_sign),
		.c_exp_sum(c_exp_sum), .c_product(c_product),
		.c_class_1(c_class_1), .c_class_2(c_class_2), .c_snan(c_snan)
	);

	fp_normalize_round u_round (
		.c_rnd(c_rnd), .c_sign(c_sign), .c_exp_sum(c_exp_sum), .c_product(c_product),
		.rnd_exp(rnd_exp), .rnd_frac(rnd_frac), .overflow(overflow),
		.underflow(underflow), .inexact(inexact), .max_finite(max_finite)
	);

	fp_result_pack u_pack (
		.c_sign(c_sign), .c_class_1(c_class_1), .c_class_2(c_class_2), .c_snan(c_snan),
		.rnd_exp(rnd_exp), .rnd_frac(rnd_frac), .overflow(overflow),
		.underflow(underflow), .inexact(inexact), .max_finite(max_finite),
		.res(res), .nv(nv), .of(of), .uf(uf), .nx(nx)
	);

	assign valid   = c_valid;	// result leaves from stage c
	assign tag_out = c_tag;

endmodule

// ==== verilog/fp_result_pack.sv ====
// fp_result_pack: chooses the special case or rounded result and raises the exception flags
`timescale 1ns/1ps

module fp_result_pack import fp_mul_pkg::*; (
	input  logic              c_sign,
	input  fp_class_t         c_class_1,
	input  fp_class_t         c_class_2,
	input  logic              c_snan,
	input  logic [EXP_W-1:0]  rnd_exp,
	input  logic [FRAC_W-1:0] rnd_frac,
	input  logic              overflow,
	input  logic              underflow,
	input  logic              inexact,
	input  logic              max_finite,
	output logic [FP_W-1:0]   res,
	output logic              nv,
	output logic              of,
	output logic              uf,
	output logic              nx
);

	logic any_nan, any_inf, any_zero, inf_times_zero;

	assign any_nan  = (c_class_1 == FP_NAN) || (c_class_2 == FP_NAN);
	assign any_inf  = (c_class_1 == FP_INF) || (c_class_2 == FP_INF);
	assign any_zero = (c_class_1 == FP_ZERO) || (c_class_2 == FP_ZERO);
	assign inf_times_zero = any_inf && any_zero;

	always_comb begin
		nv = 1'b0;
		of = 1'b0;
		uf = 1'b0;
		nx = 1'b0;
		if (any_nan || inf_times_zero) begin
			res = QNAN;
			nv  = c_snan || inf_times_zero;
		end else if (any_inf) begin
			res = {c_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
		end else if (any_zero) begin
			res = {c_sign, {(FP_W-1){1'b0}}};	// exact signed zero
		end else if (overflow) begin
			of = 1'b1;
			nx = 1'b1;
			if (max_finite)
				res = {c_sign, {(EXP_W-1){1'b1}}, 1'b0, {FRAC_W{1'b1}}};
			else
				res = {c_sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
		end else if (underflow) begin
			res = {c_sign, {(FP_W-1){1'b0}}};
			uf  = 1'b1;
			nx  = 1'b1;
		end else begin
			res = {c_sign, rnd_exp, rnd_frac};
			nx  = inexact;
		end
	end

endmodule

// ==== verilog/fp_normalize_round.sv ====
// fp_normalize_round: stage c normalise, round per mode and range check of the mantissa product
`timescale 1ns/1ps

module fp_normalize_round import fp_mul_pkg::*; (
	input  round_mode_t              c_rnd,
	input  logic                     c_sign,
	input  logic signed [SEXP_W-1:0] c_exp_sum,
	input  logic [PROD_W-1:0]        c_product,
	output logic [EXP_W-1:0]         rnd_exp,
	output logic [FRAC_W-1:0]        rnd_frac,
	output logic                     overflow,
	output logic                     underflow,
	output logic                     inexact,
	output logic                     max_finite
);

	logic                     norm_shift;
	logic [FRAC_W-1:0]        frac;
	logic                     guard;
	logic                     sticky;
	logic                     round_up;
	logic [FRAC_W:0]          frac_inc;
	logic                     carry;
	logic signed [SEXP_W-1:0] exp_norm;
	logic signed [SEXP_W-1:0] exp_biased;

	// product of two [1,2) mantissas lies in [1,4)
	assign norm_shift = c_product[PROD_W-1];

	always_comb begin
		if (norm_shift) begin
			frac   = c_product[PROD_W-2 -: FRAC_W];	// 46:24
			guard  = c_product[PROD_W-2-FRAC_W];
			sticky = |c_product[PROD_W-3-FRAC_W:0];
		end else begin
			frac   = c_product[PROD_W-3 -: FRAC_W];	// 45:23
			guard  = c_product[PROD_W-3-FRAC_W];
			sticky = |c_product[PROD_W-4-FRAC_W:0];
		end
	end

	assign exp_norm = c_exp_sum + SEXP_W'(norm_shift);

	// increment decision, direction taken from the sign
	always_comb begin
		case (c_rnd)
			RNE:     round_up = guard && (sticky || frac[0]);
			RTZ:     round_up = 1'b0;
			RDN:     round_up = (guard || sticky) && c_sign;
			RUP:     round_up = (guard || sticky) && !c_sign;
			RMM:     round_up = guard;
			default: round_up = 1'b0;	// reserved encodings truncate
		endcase
	end

	assign frac_inc = {1'b0, frac} + (FRAC_W+1)'(round_up);
	assign carry    = frac_inc[FRAC_W];	// all ones fraction wrapped

	assign exp_biased = exp_norm + SEXP_W'(carry) + SEXP_W'(EXP_BIAS);

	assign rnd_frac = frac_inc[FRAC_W-1:0];
	assign rnd_exp  = exp_biased[EXP_W-1:0];

	assign overflow  = exp_biased >= EXP_MAX;
	assign underflow = exp_biased < 1;	// below smallest normal, flushed
	assign inexact   = guard || sticky;

	// modes that saturate instead of going to infinity
	always_comb begin
		case (c_rnd)
			RTZ:     max_finite = 1'b1;
			RDN:     max_finite = !c_sign;
			RUP:     max_finite = c_sign;
			default: max_finite = 1'b0;
		endcase
	end

endmodule

// ==== verilog/fp_mant_multiply.sv ====
// fp_mant_multiply: stage b, forms the 24x24 mantissa product and registers it into stage c
`timescale 1ns/1ps

module fp_mant_multiply import fp_mul_pkg::*; #(
	parameter int TAG_W = 6
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     b_valid,
	input  logic [TAG_W-1:0]         b_tag,
	input  round_mode_t              b_rnd,
	input  logic                     b_sign,
	input  logic signed [SEXP_W-1:0] b_exp_sum,
	input  logic [MANT_W-1:0]        b_mant_1,
	input  logic [MANT_W-1:0]        b_mant_2,
	input  fp_class_t                b_class_1,
	input  fp_class_t                b_class_2,
	input  logic                     b_snan,
	output logic                     c_valid,
	output logic [TAG_W-1:0]         c_tag,
	output round_mode_t              c_rnd,
	output logic                     c_sign,
	output logic signed [SEXP_W-1:0] c_exp_sum,
	output logic [PROD_W-1:0]        c_product,
	output fp_class_t                c_class_1,
	output fp_class_t                c_class_2,
	output logic                     c_snan
);

	logic [PROD_W-1:0] product;

	// plain unsigned multiply
	// a real build swaps this for a hard multiplier macro
	assign product = PROD_W'(b_mant_1) * PROD_W'(b_mant_2);

	always_ff @(posedge clk) begin
		if (reset) begin
			c_valid <= 1'b0;
		end else begin
			c_valid <= b_valid;
		end
	end

	// side information follows the product
	always_ff @(posedge clk) begin
		c_tag     <= b_tag;
		c_rnd     <= b_rnd;
		c_sign    <= b_sign;
		c_exp_sum <= b_exp_sum;
		c_product <= product;
		c_class_1 <= b_class_1;
		c_class_2 <= b_class_2;
		c_snan    <= b_snan;
	end

endmodule

// ==== verilog/fp_operand_unpack.sv ====
// fp_operand_unpack: stage a, splits and classifies both operands and registers them into stage b
`timescale 1ns/1ps

module fp_operand_unpack import fp_mul_pkg::*; #(
	parameter int TAG_W = 6
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  round_mode_t              rnd,
	input  logic [FP_W-1:0]          in_1,
	input  logic [FP_W-1:0]          in_2,
	input  logic [TAG_W-1:0]         tag,
	output logic                     b_valid,
	output logic [TAG_W-1:0]         b_tag,
	output round_mode_t              b_rnd,
	output logic                     b_sign,
	output logic signed [SEXP_W-1:0] b_exp_sum,
	output logic [MANT_W-1:0]        b_mant_1,
	output logic [MANT_W-1:0]        b_mant_2,
	output fp_class_t                b_class_1,
	output fp_class_t                b_class_2,
	output logic                     b_snan
);

	logic [EXP_W-1:0]          exp_1, exp_2;
	logic [FRAC_W-1:0]         frac_1, frac_2;
	fp_class_t                 class_1, class_2;
	logic signed [SEXP_W-1:0]  unb_1, unb_2;
	logic                      snan_1, snan_2;

	function automatic fp_class_t classify(input logic [EXP_W-1:0] e, input logic [FRAC_W-1:0] f);
		fp_class_t c;
		if (e == '0)
			c = FP_ZERO;	// subnormals flush to zero
		else if (e == EXP_W'(EXP_MAX))
			c = (f == '0) ? FP_INF : FP_NAN;
		else
			c = FP_NORMAL;
		return c;
	endfunction

	assign exp_1  = in_1[FP_W-2 -: EXP_W];
	assign exp_2  = in_2[FP_W-2 -: EXP_W];
	assign frac_1 = in_1[FRAC_W-1:0];
	assign frac_2 = in_2[FRAC_W-1:0];

	assign class_1 = classify(exp_1, frac_1);
	assign class_2 = classify(exp_2, frac_2);

	// quiet bit clear means signalling
	assign snan_1 = (class_1 == FP_NAN) && !frac_1[FRAC_W-1];
	assign snan_2 = (class_2 == FP_NAN) && !frac_2[FRAC_W-1];

	assign unb_1 = SEXP_W'(exp_1) - SEXP_W'(EXP_BIAS);
	assign unb_2 = SEXP_W'(exp_2) - SEXP_W'(EXP_BIAS);

	always_ff @(posedge clk) begin
		if (reset) begin
			b_valid <= 1'b0;
		end else begin
			b_valid <= start;
		end
	end

	always_ff @(posedge clk) begin
		b_tag     <= tag;
		b_rnd     <= rnd;
		b_sign    <= in_1[FP_W-1] ^ in_2[FP_W-1];
		b_exp_sum <= unb_1 + unb_2;
		b_mant_1  <= {exp_1 != '0, frac_1};	// hidden bit only for normals
		b_mant_2  <= {exp_2 != '0, frac_2};
		b_class_1 <= class_1;
		b_class_2 <= class_2;
		b_snan    <= snan_1 | snan_2;
	end

endmodule

// ==== verilog/fp_mul_pkg.sv ====
// fp_mul_pkg: single precision format constants and shared types for the multiplier

package fp_mul_pkg;

	// ieee 754 binary32 layout
	localparam int FP_W     = 32;
	localparam int EXP_W    = 8;
	localparam int FRAC_W   = 23;
	localparam int MANT_W   = 24;	// fraction plus hidden bit
	localparam int PROD_W   = 48;	// full mantissa product

	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 255;	// all ones exponent code

	// signed internal exponent
	// holds the sum of two unbiased exponents, the normalise and round
	// increments and the rebias without wrapping
	localparam int SEXP_W   = 10;

	localparam logic [FP_W-1:0] QNAN = 32'h7FC0_0000;	// canonical quiet nan

	// risc-v rounding mode encoding
	typedef enum logic [2:0] {
		RNE = 3'd0,	// nearest, ties to even
		RTZ = 3'd1,	// toward zero
		RDN = 3'd2,	// toward minus infinity
		RUP = 3'd3,	// toward plus infinity
		RMM = 3'd4	// nearest, ties away from zero
	} round_mode_t;

	// operand class after unpacking
	// subnormals are folded into FP_ZERO
	typedef enum logic [1:0] {
		FP_ZERO   = 2'd0,
		FP_NORMAL = 2'd1,
		FP_INF    = 2'd2,
		FP_NAN    = 2'd3
	} fp_class_t;

endpackage
